//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_game_core
RTL_TOP   ?= game_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell grep -v '^+' $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(EXE)
	@out="$$(./$(EXE))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- field_if.sv
`timescale 1ns/1ps

interface field_if #(
  parameter int n_pipes   = geom_pkg::max_pipes,
  parameter int n_goodies = geom_pkg::max_goodies
);
  import geom_pkg::*;

  // Obstacles
  coord_x_t pipe_x [n_pipes];
  coord_y_t pipe_y [n_pipes];

  // Collectables
  coord_x_t goodie_x [n_goodies];
  coord_y_t goodie_y [n_goodies];

  // Top-left corner of the player box
  coord_x_t player_x;
  coord_y_t player_y;

  modport mover (output player_x, player_y);
  modport field (output pipe_x, pipe_y, goodie_x, goodie_y);
  modport detect (input pipe_x, pipe_y, goodie_x, goodie_y, player_x, player_y);

endinterface

//--- game_core.sv
`timescale 1ns/1ps

module game_core #(
  parameter int n_pipes     = geom_pkg::max_pipes,
  parameter int n_goodies   = geom_pkg::max_goodies,
  parameter int move_period = 1000,
  parameter int win_score   = game_pkg::default_win_score
) (
  input  logic                  slower_clk,
  input  logic                  reset,
  input  logic                  btn_up,
  input  logic                  btn_down,
  input  logic                  btn_left,
  input  logic                  btn_right,
  input  logic                  start,
  output geom_pkg::coord_x_t    player_x,
  output geom_pkg::coord_y_t    player_y,
  output game_pkg::score_t      score,
  output logic                  collided,
  output game_pkg::game_state_t state
);

  logic play;
  logic initialize;

  // Positions shared by the movers and the detector
  field_if #(.n_pipes(n_pipes), .n_goodies(n_goodies)) fld ();

  player_mover u_player_mover (
    .slower_clk, .reset, .play, .initialize,
    .btn_up, .btn_down, .btn_left, .btn_right,
    .fld (fld.mover)
  );

  object_field #(
    .n_pipes(n_pipes), .n_goodies(n_goodies), .move_period(move_period)
  ) u_object_field (
    .slower_clk, .reset, .play, .initialize,
    .fld (fld.field)
  );

  hit_detector #(.n_pipes(n_pipes), .n_goodies(n_goodies)) u_hit_detector (
    .slower_clk, .reset, .play, .initialize,
    .fld (fld.detect),
    .collided, .score
  );

  game_fsm #(.win_score(win_score)) u_game_fsm (
    .slower_clk, .reset, .start, .collided, .score,
    .state, .play, .initialize
  );

  assign player_x = fld.player_x;
  assign player_y = fld.player_y;

endmodule

//--- game_fsm.sv
`timescale 1ns/1ps

module game_fsm #(
  parameter int win_score = game_pkg::default_win_score
) (
  input  logic                  slower_clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic                  collided,
  input  game_pkg::score_t      score,
  output game_pkg::game_state_t state,
  output logic                  play,
  output logic                  initialize
);
  import game_pkg::*;

  game_state_t next_state;

  //////////////////////////////////////////////////
  // Transitions
  //////////////////////////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      state_idle: begin
        if (start) begin
          next_state = state_play;
        end
      end
      // Collision beats a win seen in the same cycle
      state_play: begin
        if (collided) begin
          next_state = state_lose;
        end else if (score >= score_t'(win_score)) begin
          next_state = state_win;
        end else if (!start) begin
          next_state = state_idle;
        end
      end
      state_win, state_lose: begin
        if (!start) begin
          next_state = state_idle;
        end
      end
      default: next_state = state_idle;
    endcase
  end

  always_ff @(posedge slower_clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= next_state;
    end
  end

  // Idle doubles as the reload phase
  assign play       = (state == state_play);
  assign initialize = (state == state_idle);

endmodule

//--- game_pkg.sv
package game_pkg;

  // Two-bit game state encoding
  typedef enum logic [1:0] {
    state_idle = 2'b00,
    state_play = 2'b01,
    state_lose = 2'b10,
    state_win  = 2'b11
  } game_state_t;

  // Goodie count wide enough for the full table
  typedef logic [3:0] score_t;

  // Goodies needed to win when the top level is not overridden
  localparam int default_win_score = 9;

endpackage

//--- geom_pkg.sv
package geom_pkg;

  typedef logic [10:0] coord_x_t;
  typedef logic [9:0]  coord_y_t;

  // Rightmost column where objects re-enter
  localparam coord_x_t screen_width = 11'd1279;

  //////////////////////////////////////////////////
  // Player box and its limits
  //////////////////////////////////////////////////
  localparam int player_min_x = 10;
  localparam int player_max_x = 400;
  localparam int player_min_y = 10;
  localparam int player_max_y = 757;
  localparam int player_step  = 4;

  localparam coord_x_t player_start_x = 11'd100;
  localparam coord_y_t player_start_y = 10'd110;

  localparam int player_w = 47;
  localparam int player_h = 32;

  //////////////////////////////////////////////////
  // Pipes and goodies
  //////////////////////////////////////////////////
  localparam int pipe_w   = 100;
  localparam int pipe_h   = 30;
  localparam int goodie_w = 20;
  localparam int goodie_h = 20;

  localparam int max_pipes   = 10;
  localparam int max_goodies = 9;

  // Some pipes start just past the right edge
  localparam coord_x_t pipe_start_x [max_pipes] = '{
    11'd400, 11'd450, 11'd500, 11'd650, 11'd800,
    11'd950, 11'd1100, 11'd1280, 11'd1200, 11'd1280
  };
  localparam coord_y_t pipe_start_y [max_pipes] = '{
    10'd200, 10'd300, 10'd400, 10'd520, 10'd620,
    10'd750, 10'd630, 10'd510, 10'd450, 10'd320
  };

  localparam coord_x_t goodie_start_x [max_goodies] = '{
    11'd350, 11'd450, 11'd550, 11'd650, 11'd750,
    11'd850, 11'd950, 11'd1050, 11'd1150
  };
  localparam coord_y_t goodie_start_y [max_goodies] = '{
    10'd200, 10'd300, 10'd400, 10'd380, 10'd560,
    10'd490, 10'd637, 10'd555, 10'd710
  };

endpackage

//--- hit_detector.sv
`timescale 1ns/1ps

module hit_detector #(
  parameter int n_pipes   = geom_pkg::max_pipes,
  parameter int n_goodies = geom_pkg::max_goodies
) (
  input  logic             slower_clk,
  input  logic             reset,
  input  logic             play,
  input  logic             initialize,
  field_if.detect          fld,
  output logic             collided,
  output game_pkg::score_t score
);
  import geom_pkg::*;
  import game_pkg::*;

  logic                 pipe_hit;
  logic [n_goodies-1:0] taken;
  logic [n_goodies-1:0] new_take;
  score_t               take_cnt;

  // Boxes that only touch do not count
  function automatic logic boxes_overlap(
    coord_x_t ax, coord_y_t ay, int aw, int ah,
    coord_x_t bx, coord_y_t by, int bw, int bh
  );
    return (int'(ax) < int'(bx) + bw) && (int'(bx) < int'(ax) + aw) &&
           (int'(ay) < int'(by) + bh) && (int'(by) < int'(ay) + ah);
  endfunction

  //////////////////////////////////////////////////
  // Overlap tests on registered positions
  //////////////////////////////////////////////////
  always_comb begin
    pipe_hit = 1'b0;
    for (int i = 0; i < n_pipes; i++) begin
      if (boxes_overlap(fld.player_x, fld.player_y, player_w, player_h,
                        fld.pipe_x[i], fld.pipe_y[i], pipe_w, pipe_h)) begin
        pipe_hit = 1'b1;
      end
    end
  end

  // Only goodies not yet taken can score
  always_comb begin
    take_cnt = '0;
    for (int j = 0; j < n_goodies; j++) begin
      new_take[j] = !taken[j] &&
                    boxes_overlap(fld.player_x, fld.player_y, player_w, player_h,
                                  fld.goodie_x[j], fld.goodie_y[j], goodie_w, goodie_h);
      take_cnt = take_cnt + score_t'(new_take[j]);
    end
  end

  always_ff @(posedge slower_clk) begin
    if (reset || initialize) begin
      collided <= 1'b0;
      taken    <= '0;
      score    <= '0;
    end else if (play) begin
      if (pipe_hit) begin
        collided <= 1'b1;
      end
      taken <= taken | new_take;
      score <= score + take_cnt;
    end
  end

endmodule

//--- object_field.sv
`timescale 1ns/1ps

module object_field #(
  parameter int n_pipes     = geom_pkg::max_pipes,
  parameter int n_goodies   = geom_pkg::max_goodies,
  parameter int move_period = 1000
) (
  input  logic   slower_clk,
  input  logic   reset,
  input  logic   play,
  input  logic   initialize,
  field_if.field fld
);
  import geom_pkg::*;

  // Pipes first, then goodies, in one set of objects
  localparam int n_obj = n_pipes + n_goodies;
  // Slowest pipe sets the counter width
  localparam int cnt_w = $clog2(move_period * n_pipes + 1);

  logic [cnt_w-1:0] rate_cnt [n_obj];
  coord_x_t         obj_x    [n_obj];

  //////////////////////////////////////////////////
  // Per-object constants
  //////////////////////////////////////////////////

  // Pipe i is (i+1) times slower than a goodie
  function automatic int period_of(int k);
    if (k < n_pipes) begin
      return move_period * (k + 1);
    end
    return move_period;
  endfunction

  function automatic coord_x_t start_x_of(int k);
    if (k < n_pipes) begin
      return pipe_start_x[k];
    end
    return goodie_start_x[k - n_pipes];
  endfunction

  function automatic coord_y_t start_y_of(int k);
    if (k < n_pipes) begin
      return pipe_start_y[k];
    end
    return goodie_start_y[k - n_pipes];
  endfunction

  //////////////////////////////////////////////////
  // Leftward drift with wrap
  //////////////////////////////////////////////////
  always_ff @(posedge slower_clk) begin
    for (int k = 0; k < n_obj; k++) begin
      if (reset || initialize) begin
        rate_cnt[k] <= '0;
        obj_x[k]    <= start_x_of(k);
      end else if (play) begin
        if (rate_cnt[k] == cnt_w'(period_of(k) - 1)) begin
          rate_cnt[k] <= '0;
          obj_x[k]    <= (obj_x[k] == '0) ? screen_width : obj_x[k] - 1'b1;
        end else begin
          rate_cnt[k] <= rate_cnt[k] + 1'b1;
        end
      end
    end
  end

  // Only columns are registered since rows never change
  always_comb begin
    for (int i = 0; i < n_pipes; i++) begin
      fld.pipe_x[i] = obj_x[i];
      fld.pipe_y[i] = start_y_of(i);
    end
    for (int j = 0; j < n_goodies; j++) begin
      fld.goodie_x[j] = obj_x[n_pipes + j];
      fld.goodie_y[j] = start_y_of(n_pipes + j);
    end
  end

endmodule

//--- player_mover.sv
`timescale 1ns/1ps

module player_mover (
  input  logic   slower_clk,
  input  logic   reset,
  input  logic   play,
  input  logic   initialize,
  input  logic   btn_up,
  input  logic   btn_down,
  input  logic   btn_left,
  input  logic   btn_right,
  field_if.mover fld
);
  import geom_pkg::*;

  coord_x_t next_x;
  coord_y_t next_y;

  // One button wins, then the bounds decide if it moves at all
  always_comb begin
    next_x = fld.player_x;
    next_y = fld.player_y;
    if (btn_up) begin
      if (int'(fld.player_y) - player_step >= player_min_y) begin
        next_y = fld.player_y - coord_y_t'(player_step);
      end
    end else if (btn_down) begin
      if (int'(fld.player_y) + player_step <= player_max_y) begin
        next_y = fld.player_y + coord_y_t'(player_step);
      end
    end else if (btn_left) begin
      if (int'(fld.player_x) - player_step >= player_min_x) begin
        next_x = fld.player_x - coord_x_t'(player_step);
      end
    end else if (btn_right) begin
      if (int'(fld.player_x) + player_step <= player_max_x) begin
        next_x = fld.player_x + coord_x_t'(player_step);
      end
    end
  end

  always_ff @(posedge slower_clk) begin
    if (reset || initialize) begin
      fld.player_x <= player_start_x;
      fld.player_y <= player_start_y;
    end else if (play) begin
      fld.player_x <= next_x;
      fld.player_y <= next_y;
    end
  end

endmodule

//--- sim.f
geom_pkg.sv
game_pkg.sv
field_if.sv
player_mover.sv
object_field.sv
hit_detector.sv
game_fsm.sv
game_core.sv
tb_game_core.sv

//--- tb_game_core.sv
`timescale 1ns/1ps

module tb_game_core;
  import geom_pkg::*;
  import game_pkg::*;

  localparam int n_pipes     = 4;
  localparam int n_goodies   = 9;
  localparam int move_period = 2;
  localparam int win_score   = 3;
  localparam int n_obj       = n_pipes + n_goodies;
  localparam int rounds      = 6;
  localparam int wait_cap    = 20000;

  logic        slower_clk;
  logic        reset;
  logic        btn_up;
  logic        btn_down;
  logic        btn_left;
  logic        btn_right;
  logic        start;
  coord_x_t    player_x;
  coord_y_t    player_y;
  score_t      score;
  logic        collided;
  game_state_t state;

  // Reference model registers
  game_state_t m_state;
  int          m_px;
  int          m_py;
  int          m_score;
  bit          m_coll;
  int          m_x [n_obj];
  int          m_cnt [n_obj];
  bit          m_taken [n_goodies];

  bit force_low;
  int start_left;
  int wins;
  int losses;

  game_core #(
    .n_pipes(n_pipes), .n_goodies(n_goodies),
    .move_period(move_period), .win_score(win_score)
  ) uut (
    .slower_clk, .reset, .btn_up, .btn_down, .btn_left, .btn_right, .start,
    .player_x, .player_y, .score, .collided, .state
  );

  initial begin
    slower_clk = 1'b0;
    forever #4 slower_clk = ~slower_clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Touching edges are no hit
  function automatic bit overlaps(int ax, int ay, int aw, int ah,
                                  int bx, int by, int bw, int bh);
    return (ax < bx + bw) && (bx < ax + aw) && (ay < by + bh) && (by < ay + ah);
  endfunction

  task automatic reload_model();
    m_px    = 100;
    m_py    = 110;
    m_score = 0;
    m_coll  = 1'b0;
    for (int k = 0; k < n_obj; k++) begin
      m_cnt[k] = 0;
      if (k < n_pipes) begin
        m_x[k] = int'(pipe_start_x[k]);
      end else begin
        m_x[k] = int'(goodie_start_x[k - n_pipes]);
      end
    end
    for (int j = 0; j < n_goodies; j++) begin
      m_taken[j] = 1'b0;
    end
  endtask

  task automatic step_model();
    bit          hit;
    int          gained;
    int          per;
    bit          grab [n_goodies];
    game_state_t nxt;
    hit    = 1'b0;
    gained = 0;
    for (int i = 0; i < n_pipes; i++) begin
      if (overlaps(m_px, m_py, player_w, player_h, m_x[i], pipe_start_y[i], pipe_w, pipe_h)) begin
        hit = 1'b1;
      end
    end
    for (int j = 0; j < n_goodies; j++) begin
      grab[j] = !m_taken[j] && overlaps(m_px, m_py, player_w, player_h,
                                        m_x[n_pipes + j], goodie_start_y[j], goodie_w, goodie_h);
      gained += int'(grab[j]);
    end
    // Next state from the registered flags
    case (m_state)
      state_idle: nxt = start ? state_play : state_idle;
      state_play: begin
        if (m_coll) begin
          nxt = state_lose;
        end else if (m_score >= win_score) begin
          nxt = state_win;
        end else begin
          nxt = start ? state_play : state_idle;
        end
      end
      default: nxt = start ? m_state : state_idle;
    endcase
    if (reset || m_state == state_idle) begin
      reload_model();
    end else if (m_state == state_play) begin
      if (btn_up) begin
        if (m_py - player_step >= player_min_y) m_py -= player_step;
      end else if (btn_down) begin
        if (m_py + player_step <= player_max_y) m_py += player_step;
      end else if (btn_left) begin
        if (m_px - player_step >= player_min_x) m_px -= player_step;
      end else if (btn_right) begin
        if (m_px + player_step <= player_max_x) m_px += player_step;
      end
      for (int k = 0; k < n_obj; k++) begin
        per = (k < n_pipes) ? move_period * (k + 1) : move_period;
        if (m_cnt[k] + 1 == per) begin
          m_cnt[k] = 0;
          m_x[k]   = (m_x[k] == 0) ? int'(screen_width) : m_x[k] - 1;
        end else begin
          m_cnt[k]++;
        end
      end
      if (hit) m_coll = 1'b1;
      for (int j = 0; j < n_goodies; j++) begin
        if (grab[j]) m_taken[j] = 1'b1;
      end
      m_score += gained;
    end
    m_state = reset ? state_idle : nxt;
  endtask

  always @(posedge slower_clk) step_model();

  //////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////
  task automatic check_value(string name, int got, int exp);
    assert (got == exp) else begin
      $display("MISMATCH time=%0t %s dut=%0d model=%0d", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "output differs from the model");
    end
  endtask

  task automatic check_outputs();
    check_value("state", int'(state), int'(m_state));
    check_value("player_x", int'(player_x), m_px);
    check_value("player_y", int'(player_y), m_py);
    check_value("score", int'(score), m_score);
    check_value("collided", int'(collided), int'(m_coll));
  endtask

  // Down twice as likely as up, so the player sweeps the pipe rows
  task automatic drive_inputs();
    int r;
    int combo;
    r     = $urandom % 8;
    combo = $urandom % 16;
    btn_up    = (r == 0) || (r == 5 && combo[0]);
    btn_down  = (r == 1) || (r == 2) || (r == 5 && combo[1]);
    btn_left  = (r == 3) || (r == 5 && combo[2]);
    btn_right = (r == 4) || (r == 5 && combo[3]);
    if (force_low) begin
      start      = 1'b0;
      start_left = 0;
    end else if (start_left == 0) begin
      start      = !start;
      start_left = start ? 500 + $urandom % 2500 : 1 + $urandom % 3;
    end else begin
      start_left--;
    end
  endtask

  task automatic run_cycle();
    @(negedge slower_clk);
    check_outputs();
    drive_inputs();
  endtask

  task automatic wait_state(game_state_t a, game_state_t b, string what);
    int n;
    n = 0;
    while (state != a && state != b) begin
      run_cycle();
      n++;
      if (n >= wait_cap) begin
        $display("Timed out after %0d cycles waiting for %s", n, what);
        $display("ERRORS FOUND");
        $fatal(1, "wait timed out");
      end
    end
  endtask

  initial begin
    void'($urandom(32'hbaa3_486f));
    reset      = 1'b1;
    start      = 1'b0;
    btn_up     = 1'b0;
    btn_down   = 1'b0;
    btn_left   = 1'b0;
    btn_right  = 1'b0;
    force_low  = 1'b1;
    start_left = 0;
    wins       = 0;
    losses     = 0;
    repeat (5) @(negedge slower_clk);
    reset = 1'b0;
    // Values straight out of reset
    check_value("state", int'(state), int'(state_idle));
    check_value("player_x", int'(player_x), 100);
    check_value("player_y", int'(player_y), 110);
    check_value("score", int'(score), 0);
    check_value("collided", int'(collided), 0);
    for (int rnd = 0; rnd < rounds; rnd++) begin
      force_low = 1'b0;
      wait_state(state_play, state_play, "play");
      wait_state(state_win, state_lose, "the end of a game");
      if (state == state_win) wins++;
      else losses++;
      force_low = 1'b1;
      wait_state(state_idle, state_idle, "idle");
    end
    $display("Games won %0d, lost %0d", wins, losses);
    if (losses > 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("No game ended in a pipe collision");
      $display("ERRORS FOUND");
      $fatal(1, "collision path never exercised");
    end
  end

endmodule
